// File: include/noc_settings.svh
// Ring NoC settings
// Node count, payload width and receive queue depth shared by all blocks

`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Nodes on the ring
`define NOC_SIZE 4

// Payload width of one flit
`define NOC_DATA_WIDTH 32

// Flits held per node until read
`define NOC_RX_DEPTH 4

`endif

// File: src/noc_pkg.sv
// Ring NoC types
// Node and payload widths, the ring flit and the node port bundles

`include "noc_settings.svh"

package noc_pkg;

  typedef logic [$clog2(`NOC_SIZE)-1:0] node_id_t;
  typedef logic [`NOC_DATA_WIDTH-1:0]   data_t;

  // One packet in one ring slot
  typedef struct packed {
    logic     valid;
    node_id_t dest;
    node_id_t src;
    data_t    data;
  } flit_t;

  // Master to node
  typedef struct packed {
    logic     wvalid;
    node_id_t waddr;   // destination node
    data_t    wdata;
    logic     rready;
  } port_req_t;

  // Node to master
  typedef struct packed {
    logic     wready;
    logic     rvalid;
    data_t    rdata;
    node_id_t rsrc;    // node that sent the head flit
  } port_resp_t;

endpackage

// File: src/noc_fifo.sv
// Receive FIFO
// Circular buffer with a fall-through head; overflow and underflow are ignored

`timescale 1ns/1ps

`include "noc_settings.svh"

module noc_fifo import noc_pkg::*; #(
  parameter int DEPTH = `NOC_RX_DEPTH,
  parameter int WIDTH = $bits(flit_t)
)(
  input  logic  clk_axi,
  input  logic  rst_n,
  input  logic  push,
  input  flit_t wdata,
  input  logic  pop,
  output flit_t rdata,
  output logic  empty,
  output logic  full
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [AW-1:0]              wr_ptr;
  logic [AW-1:0]              rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign empty   = (count == '0);
  assign full    = (count == DEPTH);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk_axi) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_axi) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/noc_router.sv
// Ring router
// Each cycle the incoming slot is ejected to the local node or forwarded,
// and a free slot takes the local inject flit

`timescale 1ns/1ps

module noc_router import noc_pkg::*; (
  input  logic     clk_axi,
  input  logic     rst_n,
  input  node_id_t node_id,
  input  flit_t    ring_in,
  output flit_t    ring_out,
  input  flit_t    inject_flit,
  output logic     inject_ready,
  output flit_t    eject_flit,
  input  logic     rx_full
);
  logic  for_me;
  logic  eject;
  logic  pass_thru;
  logic  load_inject;
  flit_t slot_q;

  // Local delivery only when the receive queue has room
  assign for_me    = ring_in.valid && (ring_in.dest == node_id);
  assign eject     = for_me && !rx_full;
  assign pass_thru = ring_in.valid && !eject;

  // Through traffic has priority over the local master
  assign inject_ready = !pass_thru;
  assign load_inject  = inject_ready && inject_flit.valid;

  always_comb begin
    eject_flit       = ring_in;
    eject_flit.valid = eject;
  end

  // Slot occupancy and payload
  always_ff @(posedge clk_axi) begin
    if (!rst_n) begin
      slot_q.valid <= 1'b0;
    end else begin
      slot_q.valid <= pass_thru || load_inject;
      if (pass_thru) begin
        slot_q.dest <= ring_in.dest;
        slot_q.src  <= ring_in.src;
        slot_q.data <= ring_in.data;
      end else if (load_inject) begin
        slot_q.dest <= inject_flit.dest;
        slot_q.src  <= inject_flit.src;
        slot_q.data <= inject_flit.data;
      end
    end
  end

  assign ring_out = slot_q;

endmodule

// File: src/noc_ni.sv
// Network interface
// Turns a one-beat write into a flit for the ring, queues arriving flits
// for the reader and raises irq while any are unread

`timescale 1ns/1ps

`include "noc_settings.svh"

module noc_ni import noc_pkg::*; (
  input  logic       clk_axi,
  input  logic       rst_n,
  input  node_id_t   node_id,
  input  port_req_t  req,
  output port_resp_t resp,
  output flit_t      inject_flit,
  input  logic       inject_ready,
  input  flit_t      eject_flit,
  output logic       rx_full,
  output logic       irq
);
  flit_t rx_head;
  logic  rx_empty;
  logic  rx_pop;

  // Outgoing flit, tagged with our own node number
  always_comb begin
    inject_flit.valid = req.wvalid;
    inject_flit.dest  = req.waddr;
    inject_flit.src   = node_id;
    inject_flit.data  = req.wdata;
  end

  // Read handshake pops the head
  assign rx_pop = req.rready && !rx_empty;

  noc_fifo #(
    .DEPTH (`NOC_RX_DEPTH),
    .WIDTH ($bits(flit_t))
  ) u_rx_fifo (
    .clk_axi (clk_axi),
    .rst_n   (rst_n),
    .push    (eject_flit.valid),
    .wdata   (eject_flit),
    .pop     (rx_pop),
    .rdata   (rx_head),
    .empty   (rx_empty),
    .full    (rx_full)
  );

  // Head of the queue is presented directly
  always_comb begin
    resp.wready = inject_ready;
    resp.rvalid = !rx_empty;
    resp.rdata  = rx_head.data;
    resp.rsrc   = rx_head.src;
  end

  assign irq = !rx_empty;

endmodule

// File: src/noc_ring.sv
// Ring of NOC_SIZE nodes
// One router and one network interface per node, router k feeding router k+1

`timescale 1ns/1ps

`include "noc_settings.svh"

module noc_ring import noc_pkg::*; (
  input  logic                        clk_axi,
  input  logic                        rst_n,
  input  port_req_t  [`NOC_SIZE-1:0]  node_req,
  output port_resp_t [`NOC_SIZE-1:0]  node_resp,
  output logic       [`NOC_SIZE-1:0]  irqs
);
  // link[k] is the registered output of router k
  flit_t [`NOC_SIZE-1:0] link;
  flit_t [`NOC_SIZE-1:0] inject_flit;
  flit_t [`NOC_SIZE-1:0] eject_flit;
  logic  [`NOC_SIZE-1:0] inject_ready;
  logic  [`NOC_SIZE-1:0] rx_full;

  for (genvar k = 0; k < `NOC_SIZE; k++) begin : g_node
    localparam int PREV = (k + `NOC_SIZE - 1) % `NOC_SIZE;

    noc_router u_router (
      .clk_axi      (clk_axi),
      .rst_n        (rst_n),
      .node_id      (node_id_t'(k)),
      .ring_in      (link[PREV]),
      .ring_out     (link[k]),
      .inject_flit  (inject_flit[k]),
      .inject_ready (inject_ready[k]),
      .eject_flit   (eject_flit[k]),
      .rx_full      (rx_full[k])
    );

    noc_ni u_ni (
      .clk_axi      (clk_axi),
      .rst_n        (rst_n),
      .node_id      (node_id_t'(k)),
      .req          (node_req[k]),
      .resp         (node_resp[k]),
      .inject_flit  (inject_flit[k]),
      .inject_ready (inject_ready[k]),
      .eject_flit   (eject_flit[k]),
      .rx_full      (rx_full[k]),
      .irq          (irqs[k])
    );
  end

endmodule

// File: src/noc_wrapper.sv
// Ring NoC top level
// Steers the in and out master ports onto selected nodes and exposes
// one interrupt line per node

`timescale 1ns/1ps

`include "noc_settings.svh"

module noc_wrapper import noc_pkg::*; (
  input  logic                  clk_axi,
  input  logic                  rst_n,
  // In port placement and bundle
  input  logic                  act_in,
  input  node_id_t              sel_in,
  input  port_req_t             in_req,
  output port_resp_t            in_resp,
  // Out port placement and bundle
  input  logic                  act_out,
  input  node_id_t              sel_out,
  input  port_req_t             out_req,
  output port_resp_t            out_resp,
  // One line per node
  output logic [`NOC_SIZE-1:0]  irqs
);
  port_req_t  [`NOC_SIZE-1:0] node_req;
  port_resp_t [`NOC_SIZE-1:0] node_resp;

  // Port mux
  // in port wins when both ports pick the same node, and the out port
  // then sees an all-zero response
  always_comb begin
    in_resp  = '0;
    out_resp = '0;
    for (int i = 0; i < `NOC_SIZE; i++) begin
      node_req[i] = '0;
      if (act_in && (sel_in == node_id_t'(i))) begin
        node_req[i] = in_req;
        in_resp     = node_resp[i];
      end else if (act_out && (sel_out == node_id_t'(i))) begin
        node_req[i] = out_req;
        out_resp    = node_resp[i];
      end
    end
  end

  noc_ring u_ring (
    .clk_axi   (clk_axi),
    .rst_n     (rst_n),
    .node_req  (node_req),
    .node_resp (node_resp),
    .irqs      (irqs)
  );

endmodule

// File: tests/tb_noc_tasks.svh
// Directed test tasks for the ring NoC testbench
// Port placement, one-beat writes and reads, value checks and the tests

// Steer a master port onto a node, or park it
task automatic place_port(input bit use_out, input bit act, input int node);
  if (use_out) begin
    act_out = act;
    sel_out = node_id_t'(node);
  end else begin
    act_in = act;
    sel_in = node_id_t'(node);
  end
endtask

task automatic drive_req(input bit use_out, input port_req_t r);
  if (use_out) begin
    out_req = r;
  end else begin
    in_req = r;
  end
endtask

function automatic port_resp_t resp_of(input bit use_out);
  return use_out ? out_resp : in_resp;
endfunction

task automatic check_value(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
  assert (actual === expected) else begin
    fail_run($sformatf("Error: %s %s expected %0h actual %0h",
                       test_name, what, expected, actual));
  end
endtask

// One write beat, held until the node accepts it
task automatic write_flit(input bit use_out, input int dest, input data_t data);
  port_req_t  r;
  port_resp_t rsp;
  int         n;
  r        = '0;
  r.wvalid = 1'b1;
  r.waddr  = node_id_t'(dest);
  r.wdata  = data;
  n        = 0;
  drive_req(use_out, r);
  #1;
  rsp = resp_of(use_out);
  while (!rsp.wready) begin
    n++;
    assert (n < POLL_LIMIT) else begin
      fail_run($sformatf("%s: write to node %0d was never accepted", test_name, dest));
    end
    @(negedge clk_axi);
    #1;
    rsp = resp_of(use_out);
  end
  // Transfer on the rising edge in between
  @(negedge clk_axi);
  drive_req(use_out, '0);
endtask

// Waits for a head flit and pops it; ok stays low if none shows up
task automatic read_flit(input bit use_out, output bit ok, output data_t data,
                         output node_id_t src);
  port_req_t  r;
  port_resp_t rsp;
  int         n;
  n = 0;
  #1;
  rsp = resp_of(use_out);
  while (!rsp.rvalid && n < POLL_LIMIT) begin
    @(negedge clk_axi);
    #1;
    rsp = resp_of(use_out);
    n++;
  end
  ok   = rsp.rvalid;
  data = rsp.rdata;
  src  = rsp.rsrc;
  @(negedge clk_axi);
  if (ok) begin
    r        = '0;
    r.rready = 1'b1;
    drive_req(use_out, r);
    @(negedge clk_axi);
    drive_req(use_out, '0);
  end
endtask

task automatic read_expect(input bit use_out, input string what, input data_t exp_data,
                           input int exp_src);
  bit       ok;
  data_t    data;
  node_id_t src;
  read_flit(use_out, ok, data, src);
  assert (ok) else begin
    fail_run($sformatf("%s: no read data came for %s", test_name, what));
  end
  check_value({what, " data"}, exp_data, data);
  check_value({what, " rsrc"}, exp_src, src);
endtask

task automatic wait_irq(input int node);
  int n;
  n = 0;
  #1;
  while (!irqs[node] && n < POLL_LIMIT) begin
    @(negedge clk_axi);
    #1;
    n++;
  end
  assert (irqs[node]) else begin
    fail_run($sformatf("%s: irq of node %0d never rose", test_name, node));
  end
  @(negedge clk_axi);
endtask

task automatic check_reset_state();
  test_name = "reset_state";
  #1;
  check_value("irqs", '0, irqs);
  check_value("in_resp", '0, in_resp);
  check_value("out_resp", '0, out_resp);
  @(negedge clk_axi);
endtask

// Node 0 to node 2, read back through the out port
task automatic deliver_single();
  data_t v;
  test_name = "single_delivery";
  v = $random(seed);
  place_port(0, 1, 0);
  write_flit(0, 2, v);
  place_port(0, 0, 0);
  wait_irq(2);
  #1;
  check_value("irqs on arrival", 4'b0100, irqs);
  @(negedge clk_axi);
  place_port(1, 1, 2);
  read_expect(1, "node 2 read", v, 0);
  #1;
  check_value("irqs after read", '0, irqs);
  @(negedge clk_axi);
  place_port(1, 0, 0);
endtask

task automatic exchange_all_pairs();
  data_t    expect_data [`NOC_SIZE][`NOC_SIZE];
  bit       seen [`NOC_SIZE];
  bit       ok;
  data_t    v;
  node_id_t src;
  test_name = "all_pairs";
  for (int s = 0; s < `NOC_SIZE; s++) begin
    place_port(0, 1, s);
    for (int d = 0; d < `NOC_SIZE; d++) begin
      v = $random(seed);
      // Top byte names source and destination
      v[`NOC_DATA_WIDTH-1 -: 8] = 8'(s * 16 + d);
      expect_data[s][d] = v;
      write_flit(0, d, v);
    end
  end
  place_port(0, 0, 0);
  for (int d = 0; d < `NOC_SIZE; d++) begin
    place_port(1, 1, d);
    seen = '{default: 1'b0};
    for (int k = 0; k < `NOC_SIZE; k++) begin
      read_flit(1, ok, v, src);
      assert (ok) else begin
        fail_run($sformatf("%s: node %0d returned only %0d flits", test_name, d, k));
      end
      assert (!seen[src]) else begin
        fail_run($sformatf("%s: node %0d returned two flits from node %0d",
                           test_name, d, src));
      end
      seen[src] = 1'b1;
      check_value($sformatf("data %0d to %0d", src, d), expect_data[src][d], v);
    end
  end
  place_port(1, 0, 0);
  #1;
  check_value("irqs after all reads", '0, irqs);
  @(negedge clk_axi);
endtask

task automatic keep_order();
  data_t v [3];
  test_name = "ordering";
  place_port(0, 1, 1);
  for (int i = 0; i < 3; i++) begin
    v[i] = $random(seed);
    write_flit(0, 3, v[i]);
  end
  place_port(0, 0, 0);
  wait_irq(3);
  place_port(1, 1, 3);
  for (int i = 0; i < 3; i++) begin
    read_expect(1, $sformatf("read %0d", i), v[i], 1);
  end
  place_port(1, 0, 0);
endtask

// Extra flits circle the ring until the queue drains
task automatic survive_overflow();
  data_t    written [OVERFLOW_COUNT];
  bit       used [OVERFLOW_COUNT];
  bit       ok;
  bit       found;
  data_t    v;
  node_id_t src;
  int       count;
  test_name = "overflow";
  used  = '{default: 1'b0};
  count = 0;
  place_port(0, 1, 0);
  for (int i = 0; i < OVERFLOW_COUNT; i++) begin
    written[i] = $random(seed);
    write_flit(0, 1, written[i]);
  end
  place_port(0, 0, 0);
  place_port(1, 1, 1);
  // Drain until rvalid stays low for a whole poll window
  ok = 1'b1;
  while (ok) begin
    read_flit(1, ok, v, src);
    if (ok) begin
      count++;
      check_value("rsrc", 0, src);
      found = 1'b0;
      for (int i = 0; i < OVERFLOW_COUNT; i++) begin
        if (!found && !used[i] && written[i] == v) begin
          used[i] = 1'b1;
          found   = 1'b1;
        end
      end
      assert (found) else begin
        fail_run($sformatf("%s: node 1 returned data %0h that was not pending",
                           test_name, v));
      end
    end
  end
  check_value("flits drained", OVERFLOW_COUNT, count);
  place_port(1, 0, 0);
  #1;
  check_value("irqs after drain", '0, irqs);
  @(negedge clk_axi);
endtask

task automatic resolve_conflict();
  port_req_t r;
  data_t     v;
  test_name = "port_conflict";
  v = $random(seed);
  place_port(0, 1, 2);
  place_port(1, 1, 2);
  // Overruled out port tries to write node 3 and pop node 2
  r        = '0;
  r.wvalid = 1'b1;
  r.waddr  = node_id_t'(3);
  r.wdata  = ~v;
  r.rready = 1'b1;
  drive_req(1, r);
  write_flit(0, 2, v);
  wait_irq(2);
  #1;
  check_value("out_resp", '0, out_resp);
  check_value("irqs", 4'b0100, irqs);
  @(negedge clk_axi);
  drive_req(1, '0);
  read_expect(0, "node 2 read", v, 2);
  place_port(0, 0, 0);
  place_port(1, 0, 0);
endtask

// File: tests/tb_noc_wrapper.sv
// Testbench for the ring NoC top level
// Clock, reset, DUT, cycle limit and the directed test sequence

`timescale 1ns/1ps

`include "noc_settings.svh"

module tb_noc_wrapper import noc_pkg::*; ();
  // Bound on any single wait for the DUT
  localparam int POLL_LIMIT = 50;
  // Full sequence runs under 500 cycles, the overflow drain tail included
  localparam int MAX_CYCLES = 3000;
  // Writes that overrun one receive queue
  localparam int OVERFLOW_COUNT = `NOC_RX_DEPTH + 2;

  logic                 clk_axi;
  logic                 rst_n;
  logic                 act_in;
  node_id_t             sel_in;
  port_req_t            in_req;
  port_resp_t           in_resp;
  logic                 act_out;
  node_id_t             sel_out;
  port_req_t            out_req;
  port_resp_t           out_resp;
  logic [`NOC_SIZE-1:0] irqs;

  integer seed;
  string  test_name;
  int     cycle_count = 0;

  noc_wrapper dut0 (
    .clk_axi  (clk_axi),
    .rst_n    (rst_n),
    .act_in   (act_in),
    .sel_in   (sel_in),
    .in_req   (in_req),
    .in_resp  (in_resp),
    .act_out  (act_out),
    .sel_out  (sel_out),
    .out_req  (out_req),
    .out_resp (out_resp),
    .irqs     (irqs)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "tb_noc_tasks.svh"

  initial begin
    clk_axi = 1'b0;
    forever #2 clk_axi = ~clk_axi;
  end

  // Cycle limit
  always @(posedge clk_axi) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_run($sformatf("Run went past the limit of %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    seed      = 32'h26aa;
    test_name = "reset";
    rst_n     = 1'b0;
    act_in    = 1'b0;
    sel_in    = '0;
    in_req    = '0;
    act_out   = 1'b0;
    sel_out   = '0;
    out_req   = '0;

    // Three rising edges in reset, released on a falling edge
    repeat (3) @(posedge clk_axi);
    @(negedge clk_axi);
    rst_n = 1'b1;

    check_reset_state();
    deliver_single();
    exchange_all_pairs();
    keep_order();
    survive_overflow();
    resolve_conflict();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: noc_wrapper.f
+incdir+include
+incdir+tests
src/noc_pkg.sv
src/noc_fifo.sv
src/noc_router.sv
src/noc_ni.sv
src/noc_ring.sv
src/noc_wrapper.sv
tests/tb_noc_wrapper.sv
